// File: filelist.f
src/umi_pkg.sv
src/umi_cmd_unpack.sv
src/umi_cmd_pack.sv
src/umi_reg_bank.sv
src/umi_regif.sv
src/umi_reg_subsys.sv
verification/tb_clkgen.sv
verification/tb_umi_reg_subsys.sv

// File: run.sh
#!/bin/sh
# build the UMI register subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_umi_reg_subsys \
   -f filelist.f -o tb_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1

// File: verification/tb_umi_reg_subsys.sv
`timescale 1ns/1ps

module tb_umi_reg_subsys
   import umi_pkg::*;
   ();

   localparam int RW         = 64;
   localparam int NREGS      = 16;
   localparam int IW         = $clog2(NREGS);
   localparam int BOFF       = $clog2(RW / 8);  // byte offset bits
   localparam int GRPOFFSET  = 24;
   localparam int GRPAW      = 4;
   localparam int GRPID      = 3;
   localparam int NREQ       = 400;
   localparam int CLK_PERIOD = 40;
   localparam int TIMEOUT_NS = NREQ * 40 * CLK_PERIOD;

   logic      clk;
   logic      nreset;
   logic      req_valid;
   umi_req_t  req;
   logic      req_ready;
   logic      resp_valid;
   umi_resp_t resp;
   logic      resp_ready;

   integer        seed = 32'h88ee_ed95;
   logic [RW-1:0] model [NREGS];       // expected register contents
   umi_resp_t     exp_q [$];           // responses in request order
   int            mismatches  = 0;
   int            failures    = 0;
   int            n_accepted  = 0;
   int            n_resp      = 0;
   int            cycle       = 0;
   int            last_accept = -10;
   logic          hold_prev   = 1'b0;  // response stalled last cycle
   logic          resp_due    = 1'b0;  // response must show next cycle
   logic          bp_next     = 1'b0;  // resp_ready for the coming edge
   umi_resp_t     held;

   tb_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(5)) i_clkgen (
      .clk    (clk),
      .nreset (nreset)
   );

   umi_reg_subsys #(
      .RW        (RW),
      .NREGS     (NREGS),
      .GRPOFFSET (GRPOFFSET),
      .GRPAW     (GRPAW),
      .GRPID     (GRPID)
   ) i_umi_reg_subsys (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

   //####################
   // reporting and compares
   //####################

   task automatic report_mismatch(input string field, input string detail);
      mismatches++;
      $display("Mismatch at time %0t: %s %s", $time, field, detail);
   endtask

   task automatic report_failure(input string msg);
      failures++;
      $display("Error at time %0t: %s", $time, msg);
   endtask

   task automatic check_reg(input string field, input logic [RW-1:0] got,
                            input logic [RW-1:0] exp);
      if (got !== exp)
         report_mismatch(field, $sformatf("got %h expected %h", got, exp));
   endtask

   task automatic check_resp(input umi_resp_t got, input umi_resp_t exp);
      if (got.cmd.opcode !== exp.cmd.opcode)
         report_mismatch("resp.cmd.opcode",
            $sformatf("got %0h expected %0h", got.cmd.opcode, exp.cmd.opcode));
      if (got.cmd.size !== exp.cmd.size)
         report_mismatch("resp.cmd.size",
            $sformatf("got %0h expected %0h", got.cmd.size, exp.cmd.size));
      if (got.cmd.options !== exp.cmd.options)
         report_mismatch("resp.cmd.options",
            $sformatf("got %0h expected %0h", got.cmd.options, exp.cmd.options));
      if (got.dstaddr !== exp.dstaddr)
         report_mismatch("resp.dstaddr",
            $sformatf("got %h expected %h", got.dstaddr, exp.dstaddr));
      if (got.srcaddr !== exp.srcaddr)
         report_mismatch("resp.srcaddr",
            $sformatf("got %h expected %h", got.srcaddr, exp.srcaddr));
      for (int k = 0; k < UMI_DW / RW; k++) begin  // lane by lane
         check_reg($sformatf("resp.data lane %0d", k), got.data[RW*k +: RW],
                   exp.data[RW*k +: RW]);
      end
   endtask

   //####################
   // stimulus and model
   //####################

   task automatic make_req(output umi_req_t r);
      int               pick;
      logic [GRPAW-1:0] grp;
      r    = '0;
      pick = int'($unsigned($random(seed)) % 10);
      if (pick == 0) begin                       // roughly 10% junk opcodes
         r.cmd.opcode = 8'($random(seed));
         if (r.cmd.opcode inside {UMI_REQ_READ, UMI_REQ_WRITE, UMI_REQ_POSTED})
            r.cmd.opcode = 8'hff;
      end else if (pick < 5) begin
         r.cmd.opcode = UMI_REQ_READ;
      end else if (pick < 8) begin
         r.cmd.opcode = UMI_REQ_WRITE;
      end else begin
         r.cmd.opcode = UMI_REQ_POSTED;
      end
      r.cmd.size    = 4'($random(seed) & 3);     // 1..8 bytes
      r.cmd.options = 20'($random(seed));
      r.dstaddr     = {$random(seed), $random(seed)};
      r.srcaddr     = {$random(seed), $random(seed)};
      for (int k = 0; k < UMI_DW / 32; k++) begin
         r.data[32*k +: 32] = $random(seed);
      end
      // group hit about 80% of the time
      grp = GRPAW'($random(seed));
      if (int'($unsigned($random(seed)) % 10) < 8)
         grp = GRPAW'(GRPID);
      else if (grp == GRPAW'(GRPID))
         grp = grp + GRPAW'(1);
      r.dstaddr[GRPOFFSET +: GRPAW] = grp;
   endtask

   // apply one accepted request to the model, queue what comes back
   task automatic model_accept(input umi_req_t r);
      int        idx;
      int        nbytes;
      int        start;
      logic      match;
      umi_resp_t e;
      idx   = int'(r.dstaddr[BOFF +: IW]);
      match = (r.dstaddr[GRPOFFSET +: GRPAW] == GRPAW'(GRPID));
      e             = '0;
      e.cmd.size    = r.cmd.size;
      e.cmd.options = r.cmd.options;
      e.dstaddr     = r.srcaddr;
      if (!match)
         return;                                 // swallowed silently
      case (r.cmd.opcode)
         UMI_REQ_READ: begin
            e.cmd.opcode = UMI_RESP_READ;
            for (int k = 0; k < UMI_DW / RW; k++) begin
               e.data[RW*k +: RW] = model[idx];
            end
            exp_q.push_back(e);
            resp_due = 1'b1;
         end
         UMI_REQ_WRITE, UMI_REQ_POSTED: begin
            // aligned block of 2**size bytes around the offset
            nbytes = 1 << int'(r.cmd.size);
            start  = int'(r.dstaddr[BOFF-1:0]) & ~(nbytes - 1);
            for (int b = start; b < start + nbytes; b++) begin
               model[idx][8*b +: 8] = r.data[8*b +: 8];
            end
            if (r.cmd.opcode == UMI_REQ_WRITE) begin
               e.cmd.opcode = UMI_RESP_WRITE;    // ack, no data
               exp_q.push_back(e);
               resp_due = 1'b1;
            end
         end
         default: ;
      endcase
   endtask

   // random back-pressure
   always @(posedge clk) begin
      resp_ready <= bp_next;
   end

   //####################
   // monitor, mid-cycle
   //####################

   always @(negedge clk) begin
      bp_next = ($random(seed) & 7) < 5;        // ready about 5 cycles in 8
      if (nreset) begin
         cycle++;
         if (resp_due && !resp_valid)
            report_failure("no response in the cycle after its request was accepted");
         resp_due = 1'b0;
         // a stalled response has to stay put
         if (hold_prev) begin
            if (!resp_valid)
               report_failure("resp_valid dropped before the response was taken");
            else if (resp !== held)
               report_mismatch("resp", "changed while resp_ready was low");
         end
         if (req_ready && resp_valid)
            report_failure("req_ready high while a response was waiting");
         hold_prev = resp_valid && !resp_ready;
         held      = resp;
         if (resp_valid && resp_ready) begin     // leaves on the next edge
            n_resp++;
            if (exp_q.size() == 0)
               report_failure("a response arrived when none was expected");
            else
               check_resp(resp, exp_q.pop_front());
         end
         if (req_valid && req_ready) begin       // accepted on the next edge
            if (last_accept == cycle - 1)
               report_failure("requests accepted on consecutive cycles");
            last_accept = cycle;
            n_accepted++;
            model_accept(req);
         end
      end
   end

   //####################
   // main sequence
   //####################

   initial begin
      umi_req_t r;
      int       drain;
      req_valid  = 1'b0;
      req        = '0;
      resp_ready = 1'b0;
      foreach (model[i]) model[i] = '0;          // bank resets to zero
      wait (nreset === 1'b1);
      @(negedge clk);
      if (req_ready !== 1'b1 || resp_valid !== 1'b0)
         report_failure("req_ready not high or resp_valid not low after reset");
      @(posedge clk);
      for (int n = 0; n < NREQ; n++) begin
         make_req(r);
         req_valid <= 1'b1;
         req       <= r;
         @(negedge clk);
         while (req_ready !== 1'b1) @(negedge clk);
         @(posedge clk);                         // accept edge
         if (($random(seed) & 3) == 0) begin     // occasional idle gap
            req_valid <= 1'b0;
            repeat (1 + ($random(seed) & 3)) @(posedge clk);
         end
      end
      req_valid <= 1'b0;
      drain = 0;
      while (exp_q.size() != 0 && drain < 200) begin
         @(posedge clk);
         drain++;
      end
      repeat (10) @(posedge clk);                // room for strays
      if (exp_q.size() != 0)
         report_failure($sformatf("%0d responses never arrived", exp_q.size()));
      if (n_accepted != NREQ)
         report_failure($sformatf("only %0d of %0d requests accepted", n_accepted, NREQ));
      $display("requests accepted %0d, responses seen %0d", n_accepted, n_resp);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD     = 40,  // ns
   parameter int RST_CYCLES = 5    // clocks held in reset
) (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // release on a rising edge, like any other synchronous input
   initial begin
      nreset = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      nreset <= 1'b1;
   end

endmodule

// File: src/umi_reg_subsys.sv
`timescale 1ns/1ps

module umi_reg_subsys
   import umi_pkg::*;
   #(
   parameter int RW        = 64,  // register width
   parameter int NREGS     = 16,  // register count
   parameter int GRPOFFSET = 24,  // group field lsb
   parameter int GRPAW     = 4,   // group field width
   parameter int GRPID     = 3    // group id
   )
   (
   input  logic      clk,
   input  logic      nreset,
   // request channel
   input  logic      req_valid,
   input  umi_req_t  req,
   output logic      req_ready,
   // response channel
   output logic      resp_valid,
   output umi_resp_t resp,
   input  logic      resp_ready
   );

   // register port
   logic [UMI_AW-1:0] reg_addr;
   logic              reg_read;
   logic              reg_write;
   logic [3:0]        reg_size;
   logic [RW-1:0]     reg_wrdata;
   logic [RW-1:0]     reg_rddata;

   umi_regif #(
      .RW        (RW),
      .GRPOFFSET (GRPOFFSET),
      .GRPAW     (GRPAW),
      .GRPID     (GRPID)
   ) i_umi_regif (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready),
      .reg_addr   (reg_addr),
      .reg_read   (reg_read),
      .reg_write  (reg_write),
      .reg_size   (reg_size),
      .reg_wrdata (reg_wrdata),
      .reg_rddata (reg_rddata)
   );

   umi_reg_bank #(
      .RW    (RW),
      .NREGS (NREGS)
   ) i_umi_reg_bank (
      .clk        (clk),
      .nreset     (nreset),
      .reg_addr   (reg_addr),
      .reg_read   (reg_read),
      .reg_write  (reg_write),
      .reg_size   (reg_size),
      .reg_wrdata (reg_wrdata),
      .reg_rddata (reg_rddata)
   );

endmodule

// File: src/umi_regif.sv
`timescale 1ns/1ps

module umi_regif
   import umi_pkg::*;
   #(
   parameter int RW        = 64,  // register width
   parameter int GRPOFFSET = 24,  // group field lsb in dstaddr
   parameter int GRPAW     = 4,   // group field width
   parameter int GRPID     = 3    // our group
   )
   (
   input  logic              clk,
   input  logic              nreset,      // async, active low
   // umi request
   input  logic              req_valid,
   input  umi_req_t          req,
   output logic              req_ready,
   // umi response
   output logic              resp_valid,
   output umi_resp_t         resp,
   input  logic              resp_ready,
   // register port
   output logic [UMI_AW-1:0] reg_addr,
   output logic              reg_read,    // 1-cycle strobe
   output logic              reg_write,   // 1-cycle strobe
   output logic [3:0]        reg_size,
   output logic [RW-1:0]     reg_wrdata,
   input  logic [RW-1:0]     reg_rddata   // same-cycle readback
   );

   // ready / gap after drop / response pending
   typedef enum logic [1:0] {
      ST_READY,
      ST_GAP,
      ST_WAIT
   } state_e;

   state_e         state;
   state_e         state_nxt;
   umi_req_class_e req_class;
   logic [19:0]    req_options;
   logic           accept;
   logic           group_match;
   logic           is_read;
   logic           is_write;
   logic           need_resp;
   logic [7:0]     resp_opcode;
   umi_cmd_t       resp_cmd;
   umi_resp_t      resp_nxt;
   umi_resp_t      resp_q;

   //####################
   // request decode
   //####################

   umi_cmd_unpack i_cmd_unpack (
      .cmd       (req.cmd),
      .req_class (req_class),
      .size      (reg_size),
      .options   (req_options)
   );

   assign accept      = req_valid & req_ready;
   // group field must carry our id, otherwise silently eaten
   assign group_match = (req.dstaddr[GRPOFFSET +: GRPAW] == GRPAW'(GRPID));

   assign is_read   = (req_class == REQ_READ);
   assign is_write  = (req_class == REQ_WRITE) | (req_class == REQ_POSTED);
   assign need_resp = accept & group_match &
                      ((req_class == REQ_READ) | (req_class == REQ_WRITE));

   // register port strobes
   assign reg_addr   = req.dstaddr;
   assign reg_read   = accept & group_match & is_read;
   assign reg_write  = accept & group_match & is_write;  // posted too
   assign reg_wrdata = req.data[RW-1:0];                 // low lanes only

   //####################
   // flow control
   //####################

   always_comb begin
      state_nxt = state;
      case (state)
         ST_READY: begin
            if (accept)
               state_nxt = need_resp ? ST_WAIT : ST_GAP;
         end
         ST_GAP:   state_nxt = ST_READY;  // one dead cycle
         ST_WAIT: begin
            if (resp_ready)  // response leaves this edge
               state_nxt = ST_READY;
         end
         default:  state_nxt = ST_READY;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         state <= ST_READY;
      else
         state <= state_nxt;
   end

   assign req_ready  = (state == ST_READY);
   assign resp_valid = (state == ST_WAIT);

   //####################
   // response build
   //####################

   assign resp_opcode = is_read ? UMI_RESP_READ : UMI_RESP_WRITE;

   umi_cmd_pack i_cmd_pack (
      .opcode  (resp_opcode),
      .size    (reg_size),
      .options (req_options),
      .cmd     (resp_cmd)
   );

   always_comb begin
      resp_nxt.cmd     = resp_cmd;
      resp_nxt.dstaddr = req.srcaddr;  // back to requester
      resp_nxt.srcaddr = '0;
      // read data fills every lane, write ack carries none
      resp_nxt.data    = is_read ? {(UMI_DW/RW){reg_rddata}} : '0;
   end

   // held until taken, captured at the accept edge
   always_ff @(posedge clk) begin
      if (need_resp)
         resp_q <= resp_nxt;
   end

   assign resp = resp_q;

endmodule

// File: src/umi_reg_bank.sv
`timescale 1ns/1ps

module umi_reg_bank
   import umi_pkg::*;
   #(
   parameter int RW    = 64,  // register width, multiple of 8
   parameter int NREGS = 16   // power of two
   )
   (
   input  logic              clk,
   input  logic              nreset,
   input  logic [UMI_AW-1:0] reg_addr,
   input  logic              reg_read,
   input  logic              reg_write,
   input  logic [3:0]        reg_size,    // log2 of bytes
   input  logic [RW-1:0]     reg_wrdata,
   output logic [RW-1:0]     reg_rddata
   );

   localparam int NBYTES = RW / 8;
   localparam int BOFF   = $clog2(NBYTES);  // byte offset bits
   localparam int IW     = $clog2(NREGS);   // index bits

   logic [RW-1:0]     regs [NREGS];
   logic [IW-1:0]     idx;
   logic [BOFF-1:0]   offset;
   logic [3:0]        size_eff;
   logic [NBYTES-1:0] byte_en;

   //####################
   // address split
   //####################

   assign idx    = reg_addr[BOFF +: IW];  // wraps modulo NREGS
   assign offset = reg_addr[BOFF-1:0];

   // anything wider than a register writes the whole register
   assign size_eff = (reg_size > 4'(BOFF)) ? 4'(BOFF) : reg_size;

   //####################
   // byte lane enables
   //####################

   // lane hit when it sits in the same aligned 2**size block as offset
   always_comb begin
      for (int b = 0; b < NBYTES; b++) begin
         byte_en[b] = ((BOFF'(b) ^ offset) >> size_eff) == '0;
      end
   end

   //####################
   // storage
   //####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_write) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (byte_en[b])
               regs[idx][8*b +: 8] <= reg_wrdata[8*b +: 8];  // same lane in
         end
      end
   end

   // whole register out, requester picks bytes, zero when idle
   assign reg_rddata = reg_read ? regs[idx] : '0;

endmodule

// File: src/umi_cmd_pack.sv
`timescale 1ns/1ps

module umi_cmd_pack
   import umi_pkg::*;
   (
   input  logic [7:0]  opcode,   // response opcode
   input  logic [3:0]  size,     // copied from request
   input  logic [19:0] options,  // copied from request
   output umi_cmd_t    cmd       // assembled response command
   );

   // field placement lives in umi_cmd_t
   always_comb begin
      cmd         = '0;
      cmd.opcode  = opcode;
      cmd.size    = size;
      cmd.options = options;
   end

endmodule

// File: src/umi_cmd_unpack.sv
`timescale 1ns/1ps

module umi_cmd_unpack
   import umi_pkg::*;
   (
   input  umi_cmd_t       cmd,        // request command word
   output umi_req_class_e req_class,  // decoded request kind
   output logic [3:0]     size,       // log2 of access bytes
   output logic [19:0]    options     // echoed back in the response
   );

   //####################
   // opcode decode
   //####################

   always_comb begin
      case (cmd.opcode)
         UMI_REQ_READ:   req_class = REQ_READ;
         UMI_REQ_WRITE:  req_class = REQ_WRITE;
         UMI_REQ_POSTED: req_class = REQ_POSTED;
         default:        req_class = REQ_NONE;  // dropped by regif
      endcase
   end

   //####################
   // field extract
   //####################

   assign size    = cmd.size;     // same for reads and writes
   assign options = cmd.options;  // not interpreted here

endmodule

// File: src/umi_pkg.sv
package umi_pkg;

   //####################
   // bus geometry
   //####################

   localparam int UMI_AW = 64;   // address width
   localparam int UMI_DW = 256;  // packet data width

   //####################
   // command word
   //####################

   // 32-bit command, options on top, opcode in the low byte
   typedef struct packed {
      logic [19:0] options;  // 31..12, passed through to the response
      logic [3:0]  size;     // 11..8, bytes = 2**size
      logic [7:0]  opcode;   // 7..0
   } umi_cmd_t;

   // request opcodes
   localparam logic [7:0] UMI_REQ_READ   = 8'd1;
   localparam logic [7:0] UMI_REQ_WRITE  = 8'd3;  // non-posted, wants an ack
   localparam logic [7:0] UMI_REQ_POSTED = 8'd5;  // fire and forget

   // response opcodes
   localparam logic [7:0] UMI_RESP_READ  = 8'd2;
   localparam logic [7:0] UMI_RESP_WRITE = 8'd4;

   //####################
   // packets
   //####################

   // request packet as seen on the device side
   typedef struct packed {
      umi_cmd_t            cmd;
      logic [UMI_AW-1:0]   dstaddr;  // register address + group field
      logic [UMI_AW-1:0]   srcaddr;  // return address for the response
      logic [UMI_DW-1:0]   data;     // write data in the low lanes
   } umi_req_t;

   // response packet, same layout
   typedef struct packed {
      umi_cmd_t            cmd;
      logic [UMI_AW-1:0]   dstaddr;  // request srcaddr
      logic [UMI_AW-1:0]   srcaddr;  // always zero here
      logic [UMI_DW-1:0]   data;     // read value, replicated
   } umi_resp_t;

   //####################
   // decoded request
   //####################

   // what the register slave does with a request
   typedef enum logic [1:0] {
      REQ_NONE,    // unknown opcode, accept and drop
      REQ_READ,
      REQ_WRITE,
      REQ_POSTED
   } umi_req_class_e;

endpackage
